// File: Makefile
# Verilator simulation of the chipbus testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module chipbus_tb -f chipbus.f -o chipbus_sim
	./obj_dir/chipbus_sim > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: chipbus.f
+incdir+verilog
verilog/chipbus_pkg.sv
verilog/bus_req_if.sv
verilog/mem_decoder.sv
verilog/bus_arbiter.sv
verilog/sram_bridge.sv
verilog/chipbus_top.sv
dv/chipbus_tb.sv

// File: dv/chipbus_tb.sv
// ---------------------------------------------------------------------
// chipbus testbench
// drives cpu and dma accesses from the test file, models the sram,
// checks read data, sram addresses and dma priority on a tie
// ---------------------------------------------------------------------
`include "chipbus_config.svh"

module chipbus_tb;
  import chipbus_pkg::*;

  localparam int MEM_WORDS = 1 << `CB_RAM_AW;  // 2M words

  logic       clk;
  logic       reset;
  logic       cpu_req;
  cpu_addr_t  cpu_addr;
  logic       cpu_we;
  byte_en_t   cpu_be;
  word_t      cpu_wdata;
  logic       cpu_ack;
  word_t      cpu_rdata;
  logic       dma_req;
  dma_addr_t  dma_addr;
  logic       dma_we;
  byte_en_t   dma_be;
  word_t      dma_wdata;
  logic       dma_ack;
  word_t      dma_rdata;
  chip_size_e chip_size;
  logic       ovl;
  ram_addr_t  ram_addr;
  word_t      ram_wdata;
  word_t      ram_data_in;
  logic       ram_we_n;
  logic       ram_oe_n;
  logic       ram_bhe_n;
  logic       ram_ble_n;

  // sram model state
  word_t      ram_mem [MEM_WORDS];
  bit         preloaded;
  int         strobe_cnt;       // cycles with oe or we low
  ram_addr_t  strobe_addr;      // address seen at the latest strobe

  int         cycle_cnt = 0;
  int         cycle_limit = 1000;  // replaced once the tests are read
  logic [31:0] lcg_state = 32'd31;
  word_t      last_rnd;         // latest random write word

  // one entry per test line
  master_e     t_master [$];
  logic        t_both [$];      // dma write and cpu read at once
  logic        t_we [$];
  logic [23:0] t_addr [$];      // cpu byte address
  byte_en_t    t_be [$];
  word_t       t_wdata [$];
  logic        t_wrnd [$];      // write data from the lcg
  logic [1:0]  t_chip [$];
  logic        t_ovl [$];
  word_t       t_exp [$];
  logic        t_exp_skip [$];  // read data not checked
  logic        t_exp_rnd [$];   // expect the latest random word
  ram_addr_t   t_ram [$];
  logic        t_no_ram [$];    // no sram cycle allowed

  chipbus_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .cpu_req_i   (cpu_req),
    .cpu_addr_i  (cpu_addr),
    .cpu_we_i    (cpu_we),
    .cpu_be_i    (cpu_be),
    .cpu_wdata_i (cpu_wdata),
    .cpu_ack_o   (cpu_ack),
    .cpu_rdata_o (cpu_rdata),
    .dma_req_i   (dma_req),
    .dma_addr_i  (dma_addr),
    .dma_we_i    (dma_we),
    .dma_be_i    (dma_be),
    .dma_wdata_i (dma_wdata),
    .dma_ack_o   (dma_ack),
    .dma_rdata_o (dma_rdata),
    .chip_size_i (chip_size),
    .ovl_i       (ovl),
    .ram_addr_o  (ram_addr),
    .ram_data_o  (ram_wdata),
    .ram_data_i  (ram_data_in),
    .ram_we_n_o  (ram_we_n),
    .ram_oe_n_o  (ram_oe_n),
    .ram_bhe_n_o (ram_bhe_n),
    .ram_ble_n_o (ram_ble_n)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 unit period
  end

  // ---------------------------------------------------------------------
  // sram model preloaded on reset with byte lane writes
  // ---------------------------------------------------------------------
  function automatic word_t fill_word(input ram_addr_t a);
    return a[15:0] ^ {a[20:16], 11'd0};  // every address bit counts
  endfunction

  assign ram_data_in = ram_mem[ram_addr];  // async read

  always @(posedge clk) begin
    if (reset) begin
      if (!preloaded) begin
        for (int i = 0; i < MEM_WORDS; i++)
          ram_mem[ram_addr_t'(i)] = fill_word(ram_addr_t'(i));
        preloaded = 1'b1;
      end
      strobe_cnt = 0;
    end else begin
      if (!ram_we_n || !ram_oe_n) begin
        strobe_cnt++;
        strobe_addr = ram_addr;
      end
      if (!ram_we_n) begin
        if (!ram_bhe_n) ram_mem[ram_addr][15:8] = ram_wdata[15:8];
        if (!ram_ble_n) ram_mem[ram_addr][7:0] = ram_wdata[7:0];
      end
    end
  end

  // run length guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
      stop_run($sformatf("timeout: tests still running after %0d cycles", cycle_limit));
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_ram_addr(input ram_addr_t exp, input ram_addr_t got);
    if (got !== exp) begin
      stop_run($sformatf("ERR ram_addr_o expected %h got %h", exp, got));
    end
  endtask

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];  // upper bits spread better
  endfunction

  // sram cycle expected or forbidden for test t
  task automatic verify_sram_cycle(input int t, input int cnt_before);
    if (t_no_ram[t]) begin
      if (strobe_cnt != cnt_before)
        stop_run($sformatf("test %0d touched the SRAM although it was refused", t));
    end else if (strobe_cnt == cnt_before) begin
      stop_run($sformatf("test %0d made no SRAM cycle", t));
    end else begin
      check_ram_addr(t_ram[t], strobe_addr);
    end
  endtask

  task automatic parse_line(input string line);
    string       s_mst, s_we, s_addr, s_be, s_wd, s_chip, s_ovl, s_exp, s_ram;
    int          n;
    logic [23:0] ram_byte;
    n = $sscanf(line, "%s %s %s %s %s %s %s %s %s",
                s_mst, s_we, s_addr, s_be, s_wd, s_chip, s_ovl, s_exp, s_ram);
    if (n != 9) stop_run($sformatf("malformed line in test file: %s", line));
    ram_byte = 24'(s_ram.atohex());
    t_master.push_back((s_mst == "C") ? CPU : DMA);
    t_both.push_back(s_mst == "B");
    t_we.push_back(s_we == "1");
    t_addr.push_back(24'(s_addr.atohex()));
    t_be.push_back(byte_en_t'(s_be.atohex()));
    t_wdata.push_back((s_wd == "R") ? '0 : word_t'(s_wd.atohex()));
    t_wrnd.push_back(s_wd == "R");
    t_chip.push_back(2'(s_chip.atohex()));
    t_ovl.push_back(s_ovl == "1");
    t_exp.push_back(word_t'(s_exp.atohex()));
    t_exp_skip.push_back(s_exp == "-");
    t_exp_rnd.push_back(s_exp == "R");
    t_ram.push_back(ram_byte[21:1]);  // byte to word address
    t_no_ram.push_back(s_ram == "-");
  endtask

  task automatic read_tests();
    int    fd;
    string line;
    fd = $fopen("dv/chipbus_tests.txt", "r");
    if (fd == 0) stop_run("cannot open the test file dv/chipbus_tests.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment
      parse_line(line);
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    cpu_req   = 1'b0;
    cpu_addr  = '0;
    cpu_we    = 1'b0;
    cpu_be    = '0;
    cpu_wdata = '0;
    dma_req   = 1'b0;
    dma_addr  = '0;
    dma_we    = 1'b0;
    dma_be    = '0;
    dma_wdata = '0;
    chip_size = CHIP_2M;
    ovl       = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // one access by one master held until ack
  // ---------------------------------------------------------------------
  task automatic run_single(input int t);
    word_t wdata;
    word_t exp_data;
    word_t got;
    int    cnt_before;
    logic  acked;
    wdata = t_wdata[t];
    if (t_wrnd[t]) begin
      last_rnd = next_rand();
      wdata    = last_rnd;
    end
    exp_data = t_exp_rnd[t] ? last_rnd : t_exp[t];
    @(posedge clk);
    #2;
    cnt_before = strobe_cnt;
    chip_size  = chip_size_e'(t_chip[t]);
    ovl        = t_ovl[t];
    if (t_master[t] == DMA) begin
      dma_addr  = t_addr[t][20:1];  // 2MB chip window
      dma_we    = t_we[t];
      dma_be    = t_be[t];
      dma_wdata = wdata;
      dma_req   = 1'b1;
    end else begin
      cpu_addr  = t_addr[t][23:1];
      cpu_we    = t_we[t];
      cpu_be    = t_be[t];
      cpu_wdata = wdata;
      cpu_req   = 1'b1;
    end
    acked = 1'b0;
    got   = '0;
    while (!acked) begin
      @(negedge clk);  // outputs settled mid cycle
      acked = (t_master[t] == DMA) ? dma_ack : cpu_ack;
      got   = (t_master[t] == DMA) ? dma_rdata : cpu_rdata;
    end
    @(posedge clk);
    #2;
    cpu_req = 1'b0;
    dma_req = 1'b0;
    if (!t_exp_skip[t])
      check_word((t_master[t] == DMA) ? "dma_rdata_o" : "cpu_rdata_o", exp_data, got);
    verify_sram_cycle(t, cnt_before);
  endtask

  // dma write and cpu read of the same word in one cycle with dma served first
  task automatic run_both(input int t);
    word_t cpu_got;
    int    cnt_before;
    logic  dma_done;
    logic  cpu_done;
    logic  dma_seen;
    logic  cpu_seen;
    @(posedge clk);
    #2;
    cnt_before = strobe_cnt;
    chip_size  = chip_size_e'(t_chip[t]);
    ovl        = t_ovl[t];
    dma_addr   = t_addr[t][20:1];
    dma_we     = t_we[t];
    dma_be     = t_be[t];
    dma_wdata  = t_wdata[t];
    cpu_addr   = t_addr[t][23:1];
    cpu_we     = 1'b0;
    cpu_be     = 2'b11;
    cpu_wdata  = '0;
    dma_req    = 1'b1;
    cpu_req    = 1'b1;
    dma_done   = 1'b0;
    cpu_done   = 1'b0;
    cpu_got    = '0;
    while (!(dma_done && cpu_done)) begin
      @(negedge clk);
      dma_seen = dma_ack;
      cpu_seen = cpu_ack;
      if (cpu_seen && !dma_done) stop_run("CPU was acknowledged before DMA on a tie");
      if (cpu_seen) cpu_got = cpu_rdata;
      @(posedge clk);
      #2;
      if (dma_seen) begin
        dma_req  = 1'b0;
        dma_done = 1'b1;
      end
      if (cpu_seen) begin
        cpu_req  = 1'b0;
        cpu_done = 1'b1;
      end
    end
    check_word("cpu_rdata_o", t_exp[t], cpu_got);
    verify_sram_cycle(t, cnt_before);  // last strobe is the cpu read
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin
    drive_idle();
    reset = 1'b1;
    read_tests();
    if (t_master.size() == 0) stop_run("the test file holds no tests");
    cycle_limit = 10 * t_master.size() * `CB_ACCESS_CYCLES + 100;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int t = 0; t < t_master.size(); t++) begin
      if (t_both[t]) run_both(t);
      else           run_single(t);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// File: dv/chipbus_tests.txt
# master(C cpu, D dma, B both) we byte_addr be wdata chip_size ovl exp_rdata exp_ram_byte_addr
# fields in hex, R = lcg random word, - = not checked (exp_rdata) or no sram cycle (ram addr)
C 1 000000 3 1234 3 0 - 000000
C 0 000000 3 0000 3 0 1234 000000
C 0 000000 3 0000 3 1 E000 380000
C 1 000000 3 BEEF 3 1 0000 -
C 0 000000 3 0000 3 0 1234 000000
C 1 000200 3 ABCD 3 0 - 000200
C 1 000200 2 5500 3 0 - 000200
C 1 000200 1 0011 3 0 - 000200
C 0 000200 3 0000 3 0 5511 000200
C 1 C00100 3 R 3 0 - 200100
C 0 C00100 3 0000 3 0 R 200100
C 0 F80010 3 0000 3 0 E008 380010
C 1 F80010 3 5A5A 3 0 0000 -
C 0 F80010 3 0000 3 0 E008 380010
C 1 100000 3 7777 0 0 0000 -
C 0 100000 3 0000 0 0 0000 -
C 0 100000 3 0000 3 0 4000 100000
C 0 400000 3 0000 3 0 0000 -
C 0 17FFFE 3 0000 2 0 A7FF 17FFFE
C 0 180000 3 0000 2 0 0000 -
D 1 001000 3 R 3 1 - 001000
C 0 001000 3 0000 3 0 R 001000
D 0 000000 3 0000 3 1 1234 000000
B 1 002000 3 C0DE 3 0 C0DE 002000
D 0 100000 3 0000 0 0 0000 -

// File: verilog/bus_arbiter.sv
// ---------------------------------------------------------------------
// bus arbiter
// grants the sram to dma or cpu, dma wins a tie, one access per grant
// refused or unmapped accesses are acked at once with zero data
// ---------------------------------------------------------------------
module bus_arbiter (
  input  logic                    clk,
  input  logic                    reset,
  bus_req_if.arb                  cpu_if,
  bus_req_if.arb                  dma_if,
  input  chipbus_pkg::chip_size_e chip_size_i,
  input  logic                    ovl_i,
  // to sram bridge
  output logic                    start_o,     // start one ram access
  output chipbus_pkg::ram_addr_t  ram_addr_o,
  output chipbus_pkg::byte_en_t   be_o,
  output logic                    we_o,
  output chipbus_pkg::word_t      wdata_o,
  input  logic                    done_i,      // access finished
  input  chipbus_pkg::word_t      rdata_i
);
  import chipbus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,      // sampling requests
    WAIT_RAM,  // bridge busy
    ACK        // ack to owner, requests ignored
  } state_e;

  state_e    state_q;
  master_e   owner_q;       // latched at grant
  word_t     rdata_q;       // read word returned with ack
  logic      any_req;
  logic      dma_sel;       // dma has priority
  logic      mapped;        // access goes to the sram
  logic      sel_we;
  cpu_addr_t cand_addr;     // address of the candidate master
  region_e   region;
  ram_addr_t dec_ram_addr;
  logic      wr_ok;

  // ---------------------------------------------------------------------
  // candidate select and decode
  // ---------------------------------------------------------------------
  assign any_req   = cpu_if.req | dma_if.req;
  assign dma_sel   = dma_if.req;
  assign cand_addr = dma_sel ? cpu_addr_t'(dma_if.addr) : cpu_if.addr;  // zero ext
  assign sel_we    = dma_sel ? dma_if.we : cpu_if.we;

  mem_decoder u_dec (
    .addr_i      (cand_addr),
    .is_dma_i    (dma_sel),
    .chip_size_i (chip_size_i),
    .ovl_i       (ovl_i),
    .region_o    (region),
    .ram_addr_o  (dec_ram_addr),
    .wr_ok_o     (wr_ok)
  );

  assign mapped = (region != NONE) && (!sel_we || wr_ok);  // rom writes dropped

  // bridge latches these on start
  assign start_o    = (state_q == IDLE) && any_req && mapped;
  assign ram_addr_o = dec_ram_addr;
  assign we_o       = sel_we;
  assign be_o       = dma_sel ? dma_if.be : cpu_if.be;
  assign wdata_o    = dma_sel ? dma_if.wdata : cpu_if.wdata;

  // ---------------------------------------------------------------------
  // grant fsm
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      owner_q <= CPU;
    end else begin
      case (state_q)
        IDLE: begin
          if (any_req) begin
            owner_q <= dma_sel ? DMA : CPU;
            state_q <= mapped ? WAIT_RAM : ACK;  // refused goes straight to ack
          end
        end
        WAIT_RAM: begin
          if (done_i) state_q <= ACK;
        end
        default: state_q <= IDLE;  // ack lasts one cycle
      endcase
    end
  end

  // zero while idle so a refused access returns 0
  always_ff @(posedge clk) begin
    if (state_q == IDLE) rdata_q <= '0;
    else if (done_i)     rdata_q <= rdata_i;
  end

  // route ack and data back to the owner
  assign cpu_if.ack   = (state_q == ACK) && (owner_q == CPU);
  assign dma_if.ack   = (state_q == ACK) && (owner_q == DMA);
  assign cpu_if.rdata = (owner_q == CPU) ? rdata_q : '0;
  assign dma_if.rdata = (owner_q == DMA) ? rdata_q : '0;

endmodule

// File: verilog/bus_req_if.sv
// ---------------------------------------------------------------------
// bus request interface
// one master to the arbiter, level req held until a 1-cycle ack
// ---------------------------------------------------------------------
interface bus_req_if #(
  parameter type addr_t = chipbus_pkg::cpu_addr_t  // cpu or dma address
);
  import chipbus_pkg::*;

  // master side, steady while req is high
  logic     req;     // access request
  addr_t    addr;    // word address
  logic     we;      // 1 = write
  byte_en_t be;      // byte lanes
  word_t    wdata;   // write word

  // arbiter side
  logic     ack;     // one cycle, ends the access
  word_t    rdata;   // valid with ack

  modport master (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  ack,
    input  rdata
  );

  modport arb (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

// File: verilog/chipbus_config.svh
// ---------------------------------------------------------------------
// chipbus configuration
// widths, memory map bases and SRAM access length
// ---------------------------------------------------------------------
`ifndef CHIPBUS_CONFIG_SVH
`define CHIPBUS_CONFIG_SVH

// bus widths
`define CB_DATA_W        16       // data bus
`define CB_CPU_AW        23       // cpu word address, bits 23:1
`define CB_DMA_AW        20       // dma word address, 2MB chip window
`define CB_RAM_AW        21       // sram word address, 4MB part

// sram busy time per access, in clk cycles
`define CB_ACCESS_CYCLES 2

// cpu side byte bases
`define CB_SLOW_BASE     24'hC00000   // 512K slow ram
`define CB_KICK_BASE     24'hF80000   // 512K kickstart rom

// where those regions sit inside the sram, byte addresses
// chip ram always starts at sram 0
`define CB_RAM_SLOW_BASE 22'h200000
`define CB_RAM_KICK_BASE 22'h380000

`endif

// File: verilog/chipbus_pkg.sv
// ---------------------------------------------------------------------
// chipbus shared types
// addresses, data words, memory regions and bus masters
// ---------------------------------------------------------------------
`include "chipbus_config.svh"

package chipbus_pkg;

  // data and byte lanes
  typedef logic [`CB_DATA_W-1:0] word_t;
  typedef logic [1:0]            byte_en_t;  // [1] upper byte, [0] lower byte

  // word addresses, bit 0 of each is byte address bit 1
  typedef logic [`CB_CPU_AW-1:0] cpu_addr_t;  // full 16MB cpu space
  typedef logic [`CB_DMA_AW-1:0] dma_addr_t;  // chip window only
  typedef logic [`CB_RAM_AW-1:0] ram_addr_t;  // external sram

  // decoded target of an access
  typedef enum logic [1:0] {
    CHIP,   // chip ram, shared with dma
    SLOW,   // slow ram at c00000
    KICK,   // kickstart rom, read only
    NONE    // nothing mapped here
  } region_e;

  // amount of chip ram fitted, 512K steps
  typedef enum logic [1:0] {
    CHIP_512K = 2'd0,
    CHIP_1M   = 2'd1,
    CHIP_1M5  = 2'd2,
    CHIP_2M   = 2'd3
  } chip_size_e;

  // who owns the ram cycle
  typedef enum logic {
    CPU,
    DMA
  } master_e;

endpackage

// File: verilog/chipbus_top.sv
// ---------------------------------------------------------------------
// chipbus top level
// cpu and dma ports sharing one 16-bit sram through the arbiter
// ---------------------------------------------------------------------
module chipbus_top (
  input  logic                    clk,
  input  logic                    reset,
  // cpu port
  input  logic                    cpu_req_i,
  input  chipbus_pkg::cpu_addr_t  cpu_addr_i,
  input  logic                    cpu_we_i,
  input  chipbus_pkg::byte_en_t   cpu_be_i,
  input  chipbus_pkg::word_t      cpu_wdata_i,
  output logic                    cpu_ack_o,
  output chipbus_pkg::word_t      cpu_rdata_o,
  // dma port
  input  logic                    dma_req_i,
  input  chipbus_pkg::dma_addr_t  dma_addr_i,
  input  logic                    dma_we_i,
  input  chipbus_pkg::byte_en_t   dma_be_i,
  input  chipbus_pkg::word_t      dma_wdata_i,
  output logic                    dma_ack_o,
  output chipbus_pkg::word_t      dma_rdata_o,
  // memory configuration
  input  chipbus_pkg::chip_size_e chip_size_i,
  input  logic                    ovl_i,
  // sram pins
  output chipbus_pkg::ram_addr_t  ram_addr_o,
  output chipbus_pkg::word_t      ram_data_o,
  input  chipbus_pkg::word_t      ram_data_i,
  output logic                    ram_we_n_o,
  output logic                    ram_oe_n_o,
  output logic                    ram_bhe_n_o,
  output logic                    ram_ble_n_o
);
  import chipbus_pkg::*;

  bus_req_if #(.addr_t(cpu_addr_t)) cpu_bus ();
  bus_req_if #(.addr_t(dma_addr_t)) dma_bus ();

  logic      start;    // arbiter to bridge
  ram_addr_t br_addr;
  byte_en_t  br_be;
  logic      br_we;
  word_t     br_wdata;
  logic      br_done;
  word_t     br_rdata;

  // ---------------------------------------------------------------------
  // ports onto the master interfaces
  // ---------------------------------------------------------------------
  assign cpu_bus.req   = cpu_req_i;
  assign cpu_bus.addr  = cpu_addr_i;
  assign cpu_bus.we    = cpu_we_i;
  assign cpu_bus.be    = cpu_be_i;
  assign cpu_bus.wdata = cpu_wdata_i;
  assign cpu_ack_o     = cpu_bus.ack;
  assign cpu_rdata_o   = cpu_bus.rdata;

  assign dma_bus.req   = dma_req_i;
  assign dma_bus.addr  = dma_addr_i;
  assign dma_bus.we    = dma_we_i;
  assign dma_bus.be    = dma_be_i;
  assign dma_bus.wdata = dma_wdata_i;
  assign dma_ack_o     = dma_bus.ack;
  assign dma_rdata_o   = dma_bus.rdata;

  bus_arbiter u_arb (
    .clk         (clk),
    .reset       (reset),
    .cpu_if      (cpu_bus.arb),
    .dma_if      (dma_bus.arb),
    .chip_size_i (chip_size_i),
    .ovl_i       (ovl_i),
    .start_o     (start),
    .ram_addr_o  (br_addr),
    .be_o        (br_be),
    .we_o        (br_we),
    .wdata_o     (br_wdata),
    .done_i      (br_done),
    .rdata_i     (br_rdata)
  );

  sram_bridge u_sram (
    .clk         (clk),
    .reset       (reset),
    .start_i     (start),
    .addr_i      (br_addr),
    .be_i        (br_be),
    .we_i        (br_we),
    .wdata_i     (br_wdata),
    .done_o      (br_done),
    .rdata_o     (br_rdata),
    .ram_addr_o  (ram_addr_o),
    .ram_data_o  (ram_data_o),
    .ram_data_i  (ram_data_i),
    .ram_we_n_o  (ram_we_n_o),
    .ram_oe_n_o  (ram_oe_n_o),
    .ram_bhe_n_o (ram_bhe_n_o),
    .ram_ble_n_o (ram_ble_n_o)
  );

endmodule

// File: verilog/mem_decoder.sv
// ---------------------------------------------------------------------
// memory decoder
// maps a cpu or dma word address onto chip ram, slow ram or rom
// honours chip size and the kickstart overlay, rom is write protected
// ---------------------------------------------------------------------
`include "chipbus_config.svh"

module mem_decoder (
  input  chipbus_pkg::cpu_addr_t  addr_i,       // dma addresses come zero extended
  input  logic                    is_dma_i,     // access is from dma
  input  chipbus_pkg::chip_size_e chip_size_i,  // fitted chip ram
  input  logic                    ovl_i,        // rom overlay at address 0
  output chipbus_pkg::region_e    region_o,
  output chipbus_pkg::ram_addr_t  ram_addr_o,
  output logic                    wr_ok_o       // region may be written
);
  import chipbus_pkg::*;

  localparam int BANK_W = 18;  // 512K byte bank = 256K words
  localparam int CHIP_W = 20;  // 2MB chip space = 1M words

  // bases as word addresses
  localparam cpu_addr_t SLOW_W     = cpu_addr_t'(`CB_SLOW_BASE >> 1);
  localparam cpu_addr_t KICK_W     = cpu_addr_t'(`CB_KICK_BASE >> 1);
  localparam ram_addr_t RAM_SLOW_W = ram_addr_t'(`CB_RAM_SLOW_BASE >> 1);
  localparam ram_addr_t RAM_KICK_W = ram_addr_t'(`CB_RAM_KICK_BASE >> 1);

  logic              low_bank;   // first 512K of cpu space
  logic              chip_hit;   // below 2MB and under chip size
  logic              slow_hit;
  logic              kick_hit;
  logic [BANK_W-1:0] bank_off;   // word offset inside a 512K bank

  assign bank_off = addr_i[BANK_W-1:0];
  assign low_bank = addr_i[`CB_CPU_AW-1:BANK_W] == '0;

  // bank number 0..3 must not pass the fitted size
  assign chip_hit = (addr_i[`CB_CPU_AW-1:CHIP_W] == '0) &&
                    (addr_i[CHIP_W-1:BANK_W] <= chip_size_i);

  assign slow_hit = addr_i[`CB_CPU_AW-1:BANK_W] == SLOW_W[`CB_CPU_AW-1:BANK_W];
  assign kick_hit = addr_i[`CB_CPU_AW-1:BANK_W] == KICK_W[`CB_CPU_AW-1:BANK_W];

  // ---------------------------------------------------------------------
  // region select, overlay first
  // ---------------------------------------------------------------------
  always_comb begin
    region_o   = NONE;
    ram_addr_o = '0;
    if (!is_dma_i && ovl_i && low_bank) begin
      // boot overlay, cpu sees rom at 0
      region_o   = KICK;
      ram_addr_o = RAM_KICK_W + ram_addr_t'(bank_off);
    end else if (chip_hit) begin
      region_o   = CHIP;
      ram_addr_o = ram_addr_t'(addr_i[CHIP_W-1:0]);  // chip sits at sram 0
    end else if (!is_dma_i && slow_hit) begin
      region_o   = SLOW;
      ram_addr_o = RAM_SLOW_W + ram_addr_t'(bank_off);
    end else if (!is_dma_i && kick_hit) begin
      region_o   = KICK;
      ram_addr_o = RAM_KICK_W + ram_addr_t'(bank_off);
    end
  end

  // only ram takes writes
  assign wr_ok_o = (region_o == CHIP) || (region_o == SLOW);

endmodule

// File: verilog/sram_bridge.sv
// ---------------------------------------------------------------------
// sram bridge
// runs one fixed length sram access and drives the active low strobes
// ---------------------------------------------------------------------
`include "chipbus_config.svh"

module sram_bridge (
  input  logic                   clk,
  input  logic                   reset,
  // arbiter side
  input  logic                   start_i,
  input  chipbus_pkg::ram_addr_t addr_i,
  input  chipbus_pkg::byte_en_t  be_i,
  input  logic                   we_i,
  input  chipbus_pkg::word_t     wdata_i,
  output logic                   done_o,       // one cycle after the access
  output chipbus_pkg::word_t     rdata_o,
  // sram pins
  output chipbus_pkg::ram_addr_t ram_addr_o,
  output chipbus_pkg::word_t     ram_data_o,
  input  chipbus_pkg::word_t     ram_data_i,
  output logic                   ram_we_n_o,
  output logic                   ram_oe_n_o,
  output logic                   ram_bhe_n_o,
  output logic                   ram_ble_n_o
);
  import chipbus_pkg::*;

  localparam int CNT_W = (`CB_ACCESS_CYCLES > 1) ? $clog2(`CB_ACCESS_CYCLES) : 1;

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;    // cycles left after this one
  logic             done_q;
  logic             last;     // final cycle of the access
  ram_addr_t        addr_q;
  byte_en_t         be_q;
  logic             we_q;
  word_t            wdata_q;
  word_t            rdata_q;

  assign last = busy_q && (cnt_q == '0);

  // ---------------------------------------------------------------------
  // access sequencer
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= last;                     // pulse after the last cycle
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(`CB_ACCESS_CYCLES - 1);
      end else if (last) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q  <= cnt_q - CNT_W'(1);
      end
    end
  end

  // payload, held for the whole access
  always_ff @(posedge clk) begin
    if (start_i && !busy_q) begin
      addr_q  <= addr_i;
      be_q    <= be_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    if (last) rdata_q <= ram_data_i;     // sample at end of the read
  end

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  // pins
  assign ram_addr_o  = addr_q;
  assign ram_data_o  = wdata_q;
  assign ram_we_n_o  = ~(last && we_q);     // write strobe in last cycle only
  assign ram_oe_n_o  = ~(busy_q && !we_q);  // read, whole access
  assign ram_bhe_n_o = ~(busy_q && be_q[1]);
  assign ram_ble_n_o = ~(busy_q && be_q[0]);

endmodule
